/* project.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/instr_predecode.sv
rtl/instr_queue.sv
rtl/fetch_pc_gen.sv
rtl/fetch_frontend.sv
test/tb_fetch_mem.sv
test/tb_fetch_frontend.sv

/* rtl/fetch_frontend.sv */
module fetch_frontend import fetch_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  pc_t    boot_addr_i,
    // redirect from the back end
    input  logic   redirect_i,
    input  pc_t    redirect_pc_i,
    // instruction memory
    output logic   mem_req_o,
    output pc_t    mem_addr_o,
    input  logic   mem_ready_i,
    input  logic   mem_rvalid_i,
    input  instr_t mem_rdata_i,
    input  logic   mem_err_i,
    // fetch entries to the back end
    output logic   fetch_valid_o,
    input  logic   fetch_ready_i,
    output pc_t    fetch_pc_o,
    output instr_t fetch_instr_o,
    output logic   fetch_taken_o,
    output pc_t    fetch_target_o,
    output logic   fetch_fault_o
);

    pc_t  rsp_pc;
    logic pred_taken;
    pc_t  pred_target;
    logic push;
    logic space;

    // ------------------------------
    // PC generation
    // ------------------------------
    fetch_pc_gen i_fetch_pc_gen (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .redirect_i    ( redirect_i    ),
        .redirect_pc_i ( redirect_pc_i ),
        .mem_ready_i   ( mem_ready_i   ),
        .mem_rvalid_i  ( mem_rvalid_i  ),
        .mem_req_o     ( mem_req_o     ),
        .mem_addr_o    ( mem_addr_o    ),
        .pred_taken_i  ( pred_taken    ),
        .pred_target_i ( pred_target   ),
        .space_i       ( space         ),
        .rsp_pc_o      ( rsp_pc        ),
        .push_o        ( push          )
    );

    // predecode works on the raw memory response
    instr_predecode i_instr_predecode (
        .rsp_pc_i ( rsp_pc      ),
        .rdata_i  ( mem_rdata_i ),
        .err_i    ( mem_err_i   ),
        .taken_o  ( pred_taken  ),
        .target_o ( pred_target )
    );

    // ------------------------------
    // instruction queue
    // ------------------------------
    instr_queue i_instr_queue (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( redirect_i     ),
        .push_i         ( push           ),
        .pc_i           ( rsp_pc         ),
        .instr_i        ( mem_rdata_i    ),
        .taken_i        ( pred_taken     ),
        .target_i       ( pred_target    ),
        .fault_i        ( mem_err_i      ),
        .space_o        ( space          ),
        .fetch_valid_o  ( fetch_valid_o  ),
        .fetch_ready_i  ( fetch_ready_i  ),
        .fetch_pc_o     ( fetch_pc_o     ),
        .fetch_instr_o  ( fetch_instr_o  ),
        .fetch_taken_o  ( fetch_taken_o  ),
        .fetch_target_o ( fetch_target_o ),
        .fetch_fault_o  ( fetch_fault_o  )
    );

endmodule

/* rtl/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ------------------------------
// widths
// ------------------------------
// address and instruction width
`define FETCH_XLEN 32
// byte step between sequential fetches
`define FETCH_INSTR_BYTES 4

// ------------------------------
// rv32i major opcodes
// ------------------------------
`define FETCH_OPCODE_JAL    7'b1101111
`define FETCH_OPCODE_BRANCH 7'b1100011

// ------------------------------
// sizes
// ------------------------------
`define FETCH_QUEUE_DEPTH 4
// words in the program image of the memory model
`define FETCH_MEM_WORDS 256

`endif

/* rtl/fetch_pc_gen.sv */
`include "fetch_params.svh"

module fetch_pc_gen import fetch_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    // reset vector
    input  pc_t  boot_addr_i,
    // control flow change from the back end
    input  logic redirect_i,
    input  pc_t  redirect_pc_i,
    // instruction memory handshake
    input  logic mem_ready_i,
    input  logic mem_rvalid_i,
    output logic mem_req_o,
    output pc_t  mem_addr_o,
    // static prediction for the word in flight
    input  logic pred_taken_i,
    input  pc_t  pred_target_i,
    // queue has room for one more fetch
    input  logic space_i,
    // address of the outstanding request
    output pc_t  rsp_pc_o,
    // live response goes into the queue
    output logic push_o
);

    fetch_state_e state_q, state_d;
    // address of the next request
    pc_t  pc_q, pc_d;
    // address of the request in flight
    pc_t  rsp_pc_q;
    // in-flight request belongs to an old path
    logic kill_q, kill_d;

    pc_t  req_addr;
    pc_t  seq_pc;
    pc_t  next_pc;
    logic accept;
    logic rsp_arrive;

    // ------------------------------
    // memory request
    // ------------------------------
    // the boot address goes out directly in the first cycle after reset
    assign req_addr   = (state_q == FETCH_BOOT) ? boot_addr_i : pc_q;
    assign mem_addr_o = req_addr;

    // no pushes happen while requesting, so space only grows until acceptance
    // held low while in reset so no request can be taken by the memory
    assign mem_req_o  = rst_ni & (state_q != FETCH_WAIT) & space_i;
    assign accept     = mem_req_o & mem_ready_i;

    // ------------------------------
    // response side
    // ------------------------------
    assign rsp_arrive = (state_q == FETCH_WAIT) & mem_rvalid_i;
    // a redirect in the response cycle drops the word as well
    assign push_o     = rsp_arrive & ~kill_q & ~redirect_i;
    assign rsp_pc_o   = rsp_pc_q;

    // prediction wins over the sequential path
    assign seq_pc  = rsp_pc_q + pc_t'(`FETCH_INSTR_BYTES);
    assign next_pc = pred_taken_i ? pred_target_i : seq_pc;

    // ------------------------------
    // next state and next PC
    // ------------------------------
    always_comb begin : npc_select
        state_d = state_q;
        pc_d    = pc_q;
        kill_d  = kill_q;

        unique case (state_q)
            FETCH_BOOT: begin
                // hold the boot address in case the memory stalls
                pc_d    = boot_addr_i;
                state_d = accept ? FETCH_WAIT : FETCH_REQ;
            end
            FETCH_REQ: begin
                if (accept) begin
                    state_d = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = FETCH_REQ;
                    kill_d  = 1'b0;
                    // a killed response leaves the redirect target in place
                    if (!kill_q) begin
                        pc_d = next_pc;
                    end
                end
            end
            default: begin
                state_d = FETCH_BOOT;
            end
        endcase

        // redirect has the highest precedence
        if (redirect_i) begin
            pc_d = redirect_pc_i;
            // anything still outstanding after this edge is stale
            if (state_d == FETCH_WAIT) begin
                kill_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= FETCH_BOOT;
            pc_q    <= '0;
            kill_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            kill_q  <= kill_d;
        end
    end

    // capture the address on acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_pc_q <= req_addr;
        end
    end

endmodule

/* rtl/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

    // ------------------------------
    // vector types
    // ------------------------------
    // fetch address, byte granular
    typedef logic [`FETCH_XLEN-1:0] pc_t;

    // raw 32-bit instruction word
    typedef logic [`FETCH_XLEN-1:0] instr_t;

    // major opcode field, bits 6:0
    typedef logic [6:0] opcode_t;

    // ------------------------------
    // request FSM
    // ------------------------------
    // boot: present the boot address straight after reset
    // req:  request on the memory port until it is accepted
    // wait: one response outstanding
    typedef enum logic [1:0] {
        FETCH_BOOT = 2'd0,
        FETCH_REQ  = 2'd1,
        FETCH_WAIT = 2'd2
    } fetch_state_e;

endpackage

/* rtl/instr_predecode.sv */
`include "fetch_params.svh"

module instr_predecode import fetch_pkg::*; (
    // address the word was fetched from
    input  pc_t    rsp_pc_i,
    // returned instruction word
    input  instr_t rdata_i,
    // access fault on this fetch
    input  logic   err_i,
    // static prediction
    output logic   taken_o,
    output pc_t    target_o
);

    opcode_t opcode;
    logic    is_jal;
    logic    is_branch;
    pc_t     j_imm;
    pc_t     b_imm;
    pc_t     imm;

    // ------------------------------
    // instruction scan
    // ------------------------------
    assign opcode    = rdata_i[6:0];
    assign is_jal    = (opcode == `FETCH_OPCODE_JAL);
    assign is_branch = (opcode == `FETCH_OPCODE_BRANCH);

    // ------------------------------
    // immediates
    // ------------------------------
    // j-type: imm[20|10:1|11|19:12], bit 0 always zero
    assign j_imm = {
        {(`FETCH_XLEN-21){rdata_i[31]}},
        rdata_i[31],
        rdata_i[19:12],
        rdata_i[20],
        rdata_i[30:21],
        1'b0
    };

    // b-type: imm[12|10:5] in the upper bits, imm[4:1|11] in the rd slot
    assign b_imm = {
        {(`FETCH_XLEN-13){rdata_i[31]}},
        rdata_i[31],
        rdata_i[7],
        rdata_i[30:25],
        rdata_i[11:8],
        1'b0
    };

    assign imm = is_jal ? j_imm : b_imm;

    // ------------------------------
    // static prediction
    // ------------------------------
    always_comb begin : predict
        taken_o = 1'b0;
        // jal is unconditional
        if (is_jal) begin
            taken_o = 1'b1;
        end
        // backward branches are assumed to be loops
        if (is_branch && b_imm[`FETCH_XLEN-1]) begin
            taken_o = 1'b1;
        end
        // a faulted word carries no usable instruction
        if (err_i) begin
            taken_o = 1'b0;
        end
    end

    // pc-relative target, only meaningful while taken_o is high
    assign target_o = rsp_pc_i + imm;

endmodule

/* rtl/instr_queue.sv */
`include "fetch_params.svh"

module instr_queue import fetch_pkg::*; #(
    // at least two, one slot is kept for a response in flight
    parameter int unsigned DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    // redirect from the back end empties the queue
    input  logic   flush_i,
    // write side from the fetch stage
    input  logic   push_i,
    input  pc_t    pc_i,
    input  instr_t instr_i,
    input  logic   taken_i,
    input  pc_t    target_i,
    input  logic   fault_i,
    // at least two free slots
    output logic   space_o,
    // back-end port
    output logic   fetch_valid_o,
    input  logic   fetch_ready_i,
    output pc_t    fetch_pc_o,
    output instr_t fetch_instr_o,
    output logic   fetch_taken_o,
    output pc_t    fetch_target_o,
    output logic   fetch_fault_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // entry storage, one array per field
    pc_t    pc_mem     [DEPTH];
    instr_t instr_mem  [DEPTH];
    logic   taken_mem  [DEPTH];
    pc_t    target_mem [DEPTH];
    logic   fault_mem  [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;

    // ------------------------------
    // status
    // ------------------------------
    assign fetch_valid_o = (count_q != '0);
    assign pop           = fetch_valid_o & fetch_ready_i;
    assign space_o       = (count_q <= CNT_W'(DEPTH - 2));

    // head of queue
    assign fetch_pc_o     = pc_mem[rd_ptr_q];
    assign fetch_instr_o  = instr_mem[rd_ptr_q];
    assign fetch_taken_o  = taken_mem[rd_ptr_q];
    assign fetch_target_o = target_mem[rd_ptr_q];
    assign fetch_fault_o  = fault_mem[rd_ptr_q];

    // ------------------------------
    // pointers and fill count
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // wrap explicitly, depth need not be a power of two
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop);
        end
    end

    // write port
    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            pc_mem[wr_ptr_q]     <= pc_i;
            instr_mem[wr_ptr_q]  <= instr_i;
            taken_mem[wr_ptr_q]  <= taken_i;
            target_mem[wr_ptr_q] <= target_i;
            fault_mem[wr_ptr_q]  <= fault_i;
        end
    end

endmodule

/* test/tb_fetch_frontend.sv */
`include "fetch_params.svh"

module tb_fetch_frontend import fetch_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam pc_t         BOOT_ADDR      = 32'h0000_0100;
    localparam pc_t         REDIRECT_BASE  = 32'h0000_1000;
    localparam int unsigned PLAIN_ENTRIES  = 150;
    localparam int unsigned TOTAL_ENTRIES  = 500;
    localparam int unsigned FIRST_TIMEOUT  = 100;
    localparam int unsigned PHASE_TIMEOUT  = 20000;

    logic   clk_i;
    logic   rst_ni;
    pc_t    boot_addr_i;
    logic   redirect_i;
    pc_t    redirect_pc_i;
    logic   mem_req_o;
    pc_t    mem_addr_o;
    logic   mem_ready_i;
    logic   mem_rvalid_i;
    instr_t mem_rdata_i;
    logic   mem_err_i;
    logic   fetch_valid_o;
    logic   fetch_ready_i;
    pc_t    fetch_pc_o;
    instr_t fetch_instr_o;
    logic   fetch_taken_o;
    pc_t    fetch_target_o;
    logic   fetch_fault_o;

    int unsigned errors;
    int unsigned n_checked;
    int unsigned n_taken;
    int unsigned n_fault;
    int unsigned n_redirect;
    logic        redirect_en;
    logic        redirect_seen;
    pc_t         exp_pc;
    // current stretch of back-end ready or stall
    int unsigned ready_hold;
    logic        ready_level;

    fetch_frontend DUT (.*);

    tb_fetch_mem u_mem (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .mem_req_i    ( mem_req_o    ),
        .mem_addr_i   ( mem_addr_o   ),
        .mem_ready_o  ( mem_ready_i  ),
        .mem_rvalid_o ( mem_rvalid_i ),
        .mem_rdata_o  ( mem_rdata_i  ),
        .mem_err_o    ( mem_err_i    )
    );

    initial begin : clock
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int unsigned image_index(input pc_t pc);
        return (pc >> 2) % `FETCH_MEM_WORDS;
    endfunction

    // jal always, backward branch only, never on a fault
    function automatic logic predict_taken(input pc_t pc);
        int unsigned idx;
        idx = image_index(pc);
        if (u_mem.fault_img[idx]) begin
            return 1'b0;
        end
        if (u_mem.jal_img[idx]) begin
            return 1'b1;
        end
        return u_mem.branch_img[idx] && u_mem.imm_img[idx][`FETCH_XLEN-1];
    endfunction

    function automatic pc_t next_pc(input pc_t pc);
        if (predict_taken(pc)) begin
            return pc + u_mem.imm_img[image_index(pc)];
        end
        return pc + pc_t'(`FETCH_INSTR_BYTES);
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // ------------------------------
    // back-end stimulus
    // ------------------------------
    always @(posedge clk_i) begin : drive_backend
        if (rst_ni) begin
            if (ready_hold == 0) begin
                ready_level = (u_mem.rand_bits(2) != 0);
                ready_hold  = u_mem.rand_bits(3) + 1;
            end
            ready_hold = ready_hold - 1;
            fetch_ready_i <= ready_level;
            if (redirect_en && u_mem.rand_bits(5) == 0) begin
                redirect_i    <= 1'b1;
                redirect_pc_i <= REDIRECT_BASE + pc_t'(u_mem.rand_bits(8) << 2);
            end else begin
                redirect_i <= 1'b0;
            end
        end
    end

    // ------------------------------
    // monitor
    // ------------------------------
    always @(posedge clk_i) begin : monitor
        int unsigned idx;
        logic        taken;
        if (rst_ni) begin
            // flush must leave nothing at the head
            if (redirect_seen && fetch_valid_o) begin
                $display("queue still offered an entry in the cycle after a redirect");
                errors++;
            end
            if (fetch_valid_o && fetch_ready_i) begin
                idx   = image_index(exp_pc);
                taken = predict_taken(exp_pc);
                check_pc("fetch_pc_o", fetch_pc_o, exp_pc);
                check_instr("fetch_instr_o", fetch_instr_o, u_mem.image[idx]);
                check_flag("fetch_fault_o", fetch_fault_o, u_mem.fault_img[idx]);
                check_flag("fetch_taken_o", fetch_taken_o, taken);
                if (taken) begin
                    check_pc("fetch_target_o", fetch_target_o, next_pc(exp_pc));
                    n_taken++;
                end
                if (u_mem.fault_img[idx]) begin
                    n_fault++;
                end
                exp_pc = next_pc(exp_pc);
                n_checked++;
            end
            // entry popped at this edge still belonged to the old path
            if (redirect_i) begin
                exp_pc = redirect_pc_i;
                n_redirect++;
            end
            redirect_seen = redirect_i;
        end
    end

    task automatic wait_entries(input int unsigned target, input int unsigned limit,
                                output logic done);
        int unsigned cycles;
        cycles = 0;
        while (n_checked < target && cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        done = (n_checked >= target);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin : main
        logic done;
        errors        = 0;
        n_checked     = 0;
        n_taken       = 0;
        n_fault       = 0;
        n_redirect    = 0;
        redirect_en   = 1'b0;
        redirect_seen = 1'b0;
        ready_hold    = 0;
        ready_level   = 1'b0;
        exp_pc        = BOOT_ADDR;
        rst_ni        = 1'b0;
        boot_addr_i   = BOOT_ADDR;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        fetch_ready_i = 1'b0;
        repeat (4) @(posedge clk_i);
        // nothing requested or offered while reset is held
        check_flag("mem_req_o", mem_req_o, 1'b0);
        check_flag("fetch_valid_o", fetch_valid_o, 1'b0);
        rst_ni <= 1'b1;

        // boot address goes out in the first cycle after release
        @(posedge clk_i);
        check_flag("mem_req_o", mem_req_o, 1'b1);
        check_pc("mem_addr_o", mem_addr_o, BOOT_ADDR);

        wait_entries(1, FIRST_TIMEOUT, done);
        if (!done) begin
            $display("timeout: no entry came out of the queue after reset");
            errors++;
        end else begin
            // straight stream under back-pressure only
            wait_entries(PLAIN_ENTRIES, PHASE_TIMEOUT, done);
            if (!done) begin
                $display("timeout: fetch stream stalled before any redirect");
                errors++;
            end else begin
                redirect_en = 1'b1;
                wait_entries(TOTAL_ENTRIES, PHASE_TIMEOUT, done);
                if (!done) begin
                    $display("timeout: fetch stream stalled while redirects were active");
                    errors++;
                end
            end
        end

        $display("entries %0d, taken %0d, faulted %0d, redirects %0d, errors %0d",
                 n_checked, n_taken, n_fault, n_redirect, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* test/tb_fetch_mem.sv */
`include "fetch_params.svh"

module tb_fetch_mem import fetch_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    // request side, driven by the DUT
    input  logic   mem_req_i,
    input  pc_t    mem_addr_i,
    output logic   mem_ready_o,
    // response side
    output logic   mem_rvalid_o,
    output instr_t mem_rdata_o,
    output logic   mem_err_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // program image and what each word was built as
    instr_t image      [`FETCH_MEM_WORDS];
    logic   fault_img  [`FETCH_MEM_WORDS];
    logic   jal_img    [`FETCH_MEM_WORDS];
    logic   branch_img [`FETCH_MEM_WORDS];
    pc_t    imm_img    [`FETCH_MEM_WORDS];

    logic [31:0] lfsr_q;
    logic [1:0]  wait_cnt;
    pc_t         pend_addr;

    // ------------------------------
    // random source
    // ------------------------------
    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int unsigned i = 0; i < n; i++) begin
            bit_out = lfsr_q[0];
            lfsr_q  = lfsr_q >> 1;
            if (bit_out) begin
                lfsr_q = lfsr_q ^ 32'h8020_0003;
            end
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    // word address, wrapped onto the image
    function automatic int unsigned word_index(input pc_t addr);
        return (addr >> 2) % `FETCH_MEM_WORDS;
    endfunction

    // ------------------------------
    // program image
    // ------------------------------
    initial begin : fill_image
        instr_t      word;
        pc_t         imm;
        logic [1:0]  kind;
        lfsr_q = 32'hd15d;
        for (int unsigned i = 0; i < `FETCH_MEM_WORDS; i++) begin
            kind = rand_bits(2);
            // offsets of one to eight words, either direction
            imm  = pc_t'((rand_bits(3) + 1) << 2);
            if (rand_bits(1) == 1) begin
                imm = -imm;
            end
            word = rand_bits(32) ^ (i << 7);
            jal_img[i]    = 1'b0;
            branch_img[i] = 1'b0;
            case (kind)
                2'd2: begin
                    // j-type immediate, rd kept random
                    word = {imm[20], imm[10:1], imm[11], imm[19:12], word[11:7],
                            `FETCH_OPCODE_JAL};
                    jal_img[i] = 1'b1;
                end
                2'd3: begin
                    // b-type immediate, rs1 rs2 funct3 kept random
                    word = {imm[12], imm[10:5], word[24:12], imm[4:1], imm[11],
                            `FETCH_OPCODE_BRANCH};
                    branch_img[i] = 1'b1;
                end
                default: begin
                    // op-imm, never changes control flow
                    word[6:0] = 7'b0010011;
                end
            endcase
            image[i]     = word;
            imm_img[i]   = imm;
            fault_img[i] = (rand_bits(3) == 0);
        end
    end

    // ------------------------------
    // handshake model
    // ------------------------------
    always @(posedge clk_i or negedge rst_ni) begin : respond
        int unsigned delay;
        if (!rst_ni) begin
            mem_ready_o  <= 1'b0;
            mem_rvalid_o <= 1'b0;
            mem_rdata_o  <= '0;
            mem_err_o    <= 1'b0;
            wait_cnt     <= '0;
            pend_addr    <= '0;
        end else begin
            mem_rvalid_o <= 1'b0;
            mem_err_o    <= 1'b0;
            // ready about three cycles in four
            mem_ready_o  <= (rand_bits(2) != 0);
            if (mem_req_i && mem_ready_o) begin
                delay     = 1 + (rand_bits(2) % 3);
                pend_addr <= mem_addr_i;
                // shortest delay answers in the very next cycle
                if (delay == 1) begin
                    mem_rvalid_o <= 1'b1;
                    mem_rdata_o  <= image[word_index(mem_addr_i)];
                    mem_err_o    <= fault_img[word_index(mem_addr_i)];
                end
                wait_cnt <= 2'(delay - 1);
            end else if (wait_cnt != 0) begin
                if (wait_cnt == 1) begin
                    mem_rvalid_o <= 1'b1;
                    mem_rdata_o  <= image[word_index(pend_addr)];
                    mem_err_o    <= fault_img[word_index(pend_addr)];
                end
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

endmodule
